//--- logic/uart_pkg.sv
// ---------------------------------------------------------------------
// uart_pkg
// register map, widths, reset values and payload types of the axi uart
// ---------------------------------------------------------------------
package uart_pkg;

  localparam int ADDR_WIDTH     = 5;  // byte address
  localparam int DATA_WIDTH     = 32;
  localparam int ID_WIDTH       = 4;
  localparam int DIV_WIDTH      = 16; // clocks per bit
  localparam int FIFO_DEPTH     = 8;
  localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);

  localparam logic [DIV_WIDTH-1:0] DIV_RESET = 16'd434; // 115200 bps at 50 MHz

  // word index, address bits 4 to 2
  localparam logic [2:0] REG_RBR_THR = 3'd0;
  localparam logic [2:0] REG_IER     = 3'd1;
  localparam logic [2:0] REG_LCR     = 3'd3;
  localparam logic [2:0] REG_LSR     = 3'd5;
  localparam logic [2:0] REG_DIV     = 3'd7;

  localparam int LCR_DLAB_BIT = 7;

  localparam int LSR_DATA_READY   = 0;
  localparam int LSR_FRAME_ERR    = 3;
  localparam int LSR_THR_NOT_FULL = 5;
  localparam int LSR_TX_EMPTY     = 6;

  localparam logic [7:0] LSR_RESET = 8'h60; // thr not full, tx empty

  typedef logic [7:0] uart_byte_t;

  typedef struct packed {
    uart_byte_t data;
    logic       frame_err; // stop bit sampled low
  } rx_entry_t;

endpackage

//--- logic/sync_fifo.sv
// ---------------------------------------------------------------------
// sync_fifo
// first-word-fall-through FIFO, payload type set by parameter
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t = uart_pkg::uart_byte_t
) (
  input  logic     axi_aclk_i,
  input  logic     axi_aresetn_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  payload_t                              mem [uart_pkg::FIFO_DEPTH];
  logic [uart_pkg::FIFO_PTR_WIDTH-1:0]   wr_ptr;
  logic [uart_pkg::FIFO_PTR_WIDTH-1:0]   rd_ptr;
  logic [uart_pkg::FIFO_PTR_WIDTH:0]     count;
  logic                                  push_ok;
  logic                                  pop_ok;

  assign push_ok = push_i & ~full_o; // drop when full
  assign pop_ok  = pop_i & ~empty_o;
  assign empty_o = (count == '0);
  assign full_o  = (count == (uart_pkg::FIFO_PTR_WIDTH+1)'(uart_pkg::FIFO_DEPTH));
  assign data_o  = mem[rd_ptr];      // head valid while not empty

  always_ff @(posedge axi_aclk_i) begin
    if (push_ok) mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) wr_ptr <= wr_ptr + 1'b1; // depth is a power of two
      if (pop_ok)  rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // producers and consumers are expected to honour the flags
  a_no_push_full: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    !(push_i && full_o));
  a_no_pop_empty: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    !(pop_i && empty_o));

endmodule

//--- logic/uart_tx_serializer.sv
// ---------------------------------------------------------------------
// uart_tx_serializer
// pops bytes from the transmit FIFO and shifts out 8N1 frames
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module uart_tx_serializer (
  input  logic                           axi_aclk_i,
  input  logic                           axi_aresetn_i,
  input  logic [uart_pkg::DIV_WIDTH-1:0] baud_div_i,
  input  uart_pkg::uart_byte_t           fifo_data_i,
  input  logic                           fifo_empty_i,
  output logic                           fifo_pop_o,
  output logic                           busy_o,
  output logic                           uart_tx_o
);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} tx_state_t;

  tx_state_t                      state;
  logic [uart_pkg::DIV_WIDTH-1:0] cnt;     // clocks within the bit
  logic [2:0]                     bit_idx;
  uart_pkg::uart_byte_t           shreg;
  logic                           bit_end;

  assign bit_end    = (cnt == baud_div_i - 1'b1);
  assign fifo_pop_o = (state == S_IDLE) & ~fifo_empty_i; // take the head
  assign busy_o     = (state != S_IDLE);

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state     <= S_IDLE;
      cnt       <= '0;
      bit_idx   <= '0;
      uart_tx_o <= 1'b1; // line idles high
    end else begin
      cnt <= bit_end ? '0 : cnt + 1'b1;
      case (state)
        S_IDLE: begin
          cnt <= '0;
          if (fifo_pop_o) begin
            state     <= S_START;
            uart_tx_o <= 1'b0;
          end
        end
        S_START: if (bit_end) begin
          state     <= S_DATA;
          bit_idx   <= '0;
          uart_tx_o <= shreg[0]; // lsb first
        end
        S_DATA: if (bit_end) begin
          if (bit_idx == 3'd7) begin
            state     <= S_STOP;
            uart_tx_o <= 1'b1;
          end else begin
            bit_idx   <= bit_idx + 1'b1;
            uart_tx_o <= shreg[1];
          end
        end
        default: if (bit_end) state <= S_IDLE; // end of stop bit
      endcase
    end
  end

  always_ff @(posedge axi_aclk_i) begin
    if (fifo_pop_o) shreg <= fifo_data_i;
    else if (state == S_DATA && bit_end) shreg <= shreg >> 1;
  end

  a_idle_line_high: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    !busy_o |-> uart_tx_o);

endmodule

//--- logic/uart_rx_deserializer.sv
// ---------------------------------------------------------------------
// uart_rx_deserializer
// samples 8N1 frames mid-bit and pushes bytes with a framing flag
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module uart_rx_deserializer (
  input  logic                           axi_aclk_i,
  input  logic                           axi_aresetn_i,
  input  logic [uart_pkg::DIV_WIDTH-1:0] baud_div_i,
  input  logic                           uart_rx_i,
  output logic                           push_o,
  output uart_pkg::rx_entry_t            entry_o
);

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} rx_state_t;

  rx_state_t                      state;
  logic                           rx_meta;
  logic                           rx_sync;
  logic                           rx_last; // previous synced level
  logic [uart_pkg::DIV_WIDTH-1:0] cnt;
  logic [2:0]                     bit_idx;
  uart_pkg::uart_byte_t           shreg;
  logic                           bit_end;
  logic                           half_bit;

  assign bit_end  = (cnt == baud_div_i - 1'b1);
  assign half_bit = (cnt == (baud_div_i >> 1));

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
      state   <= S_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      push_o  <= 1'b0;
    end else begin
      rx_meta <= uart_rx_i;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
      push_o  <= 1'b0;
      cnt     <= cnt + 1'b1;
      case (state)
        S_IDLE: begin
          cnt <= '0;
          if (rx_last && !rx_sync) state <= S_START; // falling edge
        end
        S_START: if (half_bit) begin
          cnt     <= '0;
          bit_idx <= '0;
          state   <= rx_sync ? S_IDLE : S_DATA; // high means a glitch
        end
        S_DATA: if (bit_end) begin
          cnt <= '0;
          if (bit_idx == 3'd7) state <= S_STOP;
          else bit_idx <= bit_idx + 1'b1;
        end
        default: if (bit_end) begin
          push_o <= 1'b1; // middle of the stop bit
          state  <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge axi_aclk_i) begin
    if (state == S_DATA && bit_end) shreg <= {rx_sync, shreg[7:1]};
    if (state == S_STOP && bit_end) begin
      entry_o.data      <= shreg;
      entry_o.frame_err <= ~rx_sync;
    end
  end

endmodule

//--- logic/axi_uart_wr_ctrl.sv
// ---------------------------------------------------------------------
// axi_uart_wr_ctrl
// bus write machine, holds LCR, IER and divisor, pushes THR bytes
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module axi_uart_wr_ctrl (
  input  logic                            axi_aclk_i,
  input  logic                            axi_aresetn_i,
  input  logic [uart_pkg::ADDR_WIDTH-1:0] axi_awaddr_i,
  input  logic [uart_pkg::ID_WIDTH-1:0]   axi_awid_i,
  input  logic                            axi_awvalid_i,
  input  logic [uart_pkg::DATA_WIDTH-1:0] axi_wdata_i,
  input  logic                            axi_wvalid_i,
  input  logic                            tx_full_i,
  output logic                            axi_awready_o,
  output logic                            axi_wready_o,
  output logic                            axi_bvalid_o,
  output logic [uart_pkg::ID_WIDTH-1:0]   axi_bid_o,
  output logic                            tx_push_o,
  output uart_pkg::uart_byte_t            tx_data_o,
  output logic                            dlab_o,
  output logic                            irq_en_o,
  output logic [uart_pkg::DIV_WIDTH-1:0]  baud_div_o
);

  typedef enum logic {S_IDLE, S_ACK} wr_state_t;

  wr_state_t                      state;
  logic [uart_pkg::DIV_WIDTH-1:0] div_shadow; // moves to baud_div_o in ack
  logic [2:0]                     word_idx;
  logic                           wr_req;
  logic                           thr_ok;

  assign word_idx = axi_awaddr_i[uart_pkg::ADDR_WIDTH-1:2];
  assign wr_req   = (state == S_IDLE) & axi_awvalid_i & axi_wvalid_i;
  assign thr_ok   = wr_req & (word_idx == uart_pkg::REG_RBR_THR) & ~dlab_o & ~tx_full_i;

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state         <= S_IDLE;
      axi_awready_o <= 1'b0;
      axi_wready_o  <= 1'b0;
      axi_bvalid_o  <= 1'b0;
      axi_bid_o     <= '0;
      tx_push_o     <= 1'b0;
      dlab_o        <= 1'b0;
      irq_en_o      <= 1'b0;
      div_shadow    <= uart_pkg::DIV_RESET;
      baud_div_o    <= uart_pkg::DIV_RESET;
    end else if (state == S_IDLE) begin
      if (wr_req) begin
        state         <= S_ACK;
        axi_awready_o <= 1'b1; // refused writes are still acked
        axi_wready_o  <= 1'b1;
        axi_bvalid_o  <= 1'b1;
        axi_bid_o     <= axi_awid_i;
        tx_push_o     <= thr_ok;
        case (word_idx)
          uart_pkg::REG_IER: if (!dlab_o) irq_en_o <= axi_wdata_i[0];
          uart_pkg::REG_LCR: dlab_o <= axi_wdata_i[uart_pkg::LCR_DLAB_BIT];
          uart_pkg::REG_DIV: if (dlab_o) div_shadow <= axi_wdata_i[uart_pkg::DIV_WIDTH-1:0];
          default: ;
        endcase
      end
    end else begin
      state         <= S_IDLE;
      axi_awready_o <= 1'b0;
      axi_wready_o  <= 1'b0;
      axi_bvalid_o  <= 1'b0;
      axi_bid_o     <= '0;
      tx_push_o     <= 1'b0;
      baud_div_o    <= div_shadow;
    end
  end

  always_ff @(posedge axi_aclk_i) begin
    if (thr_ok) tx_data_o <= axi_wdata_i[7:0];
  end

  a_bvalid_pulse: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
    axi_bvalid_o |=> !axi_bvalid_o);

endmodule

//--- logic/axi_uart_rd_ctrl.sv
// ---------------------------------------------------------------------
// axi_uart_rd_ctrl
// bus read machine, registers LSR, returns RBR and LSR, drives the irq
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module axi_uart_rd_ctrl (
  input  logic                            axi_aclk_i,
  input  logic                            axi_aresetn_i,
  input  logic [uart_pkg::ADDR_WIDTH-1:0] axi_araddr_i,
  input  logic [uart_pkg::ID_WIDTH-1:0]   axi_arid_i,
  input  logic                            axi_arvalid_i,
  input  logic                            dlab_i,
  input  logic                            irq_en_i,
  input  uart_pkg::rx_entry_t             rx_head_i,
  input  logic                            rx_empty_i,
  input  logic                            tx_full_i,
  input  logic                            tx_empty_i,
  input  logic                            tx_busy_i,
  output logic                            axi_arready_o,
  output logic                            axi_rvalid_o,
  output logic [uart_pkg::DATA_WIDTH-1:0] axi_rdata_o,
  output logic [uart_pkg::ID_WIDTH-1:0]   axi_rid_o,
  output logic                            rx_pop_o,
  output logic                            read_interrupt_o
);

  typedef enum logic [1:0] {S_START, S_IDLE, S_ACK} rd_state_t;

  rd_state_t  state;
  logic [7:0] lsr_q;
  logic [7:0] lsr_d;
  logic [2:0] word_idx;

  assign word_idx = axi_araddr_i[uart_pkg::ADDR_WIDTH-1:2];

  always_comb begin
    lsr_d                             = '0;
    lsr_d[uart_pkg::LSR_DATA_READY]   = ~rx_empty_i;
    lsr_d[uart_pkg::LSR_FRAME_ERR]    = ~rx_empty_i & rx_head_i.frame_err; // flag of the head
    lsr_d[uart_pkg::LSR_THR_NOT_FULL] = ~tx_full_i;
    lsr_d[uart_pkg::LSR_TX_EMPTY]     = tx_empty_i & ~tx_busy_i;
  end

  always_ff @(posedge axi_aclk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state            <= S_START;
      axi_arready_o    <= 1'b0;
      axi_rvalid_o     <= 1'b0;
      axi_rdata_o      <= '0;
      axi_rid_o        <= '0;
      rx_pop_o         <= 1'b0;
      lsr_q            <= uart_pkg::LSR_RESET;
      read_interrupt_o <= 1'b0;
    end else begin
      lsr_q            <= lsr_d;
      read_interrupt_o <= ~rx_empty_i & irq_en_i;
      case (state)
        S_IDLE: if (axi_arvalid_i) begin
          state         <= S_ACK;
          axi_arready_o <= 1'b0;
          axi_rvalid_o  <= 1'b1;
          axi_rid_o     <= axi_arid_i;
          axi_rdata_o   <= '0; // unknown or refused reads return 0
          if (word_idx == uart_pkg::REG_RBR_THR && !dlab_i && !rx_empty_i) begin
            axi_rdata_o <= {{(uart_pkg::DATA_WIDTH-8){1'b0}}, rx_head_i.data};
            rx_pop_o    <= 1'b1;
          end else if (word_idx == uart_pkg::REG_LSR) begin
            axi_rdata_o <= {{(uart_pkg::DATA_WIDTH-8){1'b0}}, lsr_q};
          end
        end
        default: begin // start and ack both reopen the address channel
          state         <= S_IDLE;
          axi_arready_o <= 1'b1;
          axi_rvalid_o  <= 1'b0;
          rx_pop_o      <= 1'b0;
        end
      endcase
    end
  end

endmodule

//--- logic/axi_uart_top.sv
// ---------------------------------------------------------------------
// axi_uart_top
// memory-mapped UART, bus machines, FIFOs and serial engines
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module axi_uart_top (
  input  logic                            axi_aclk_i,
  input  logic                            axi_aresetn_i,
  input  logic [uart_pkg::ADDR_WIDTH-1:0] axi_araddr_i,
  input  logic [uart_pkg::ID_WIDTH-1:0]   axi_arid_i,
  input  logic                            axi_arvalid_i,
  output logic                            axi_arready_o,
  output logic                            axi_rvalid_o,
  output logic [uart_pkg::DATA_WIDTH-1:0] axi_rdata_o,
  output logic [uart_pkg::ID_WIDTH-1:0]   axi_rid_o,
  input  logic [uart_pkg::ADDR_WIDTH-1:0] axi_awaddr_i,
  input  logic [uart_pkg::ID_WIDTH-1:0]   axi_awid_i,
  input  logic                            axi_awvalid_i,
  output logic                            axi_awready_o,
  input  logic [uart_pkg::DATA_WIDTH-1:0] axi_wdata_i,
  input  logic                            axi_wvalid_i,
  output logic                            axi_wready_o,
  output logic                            axi_bvalid_o,
  output logic [uart_pkg::ID_WIDTH-1:0]   axi_bid_o,
  output logic                            read_interrupt_o,
  input  logic                            uart_rx_i,
  output logic                            uart_tx_o
);

  logic                           tx_push, tx_pop, tx_empty, tx_full, tx_busy;
  uart_pkg::uart_byte_t           tx_wdata, tx_head;
  logic                           rx_push, rx_pop, rx_empty;
  uart_pkg::rx_entry_t            rx_entry, rx_head;
  logic                           dlab, irq_en;
  logic [uart_pkg::DIV_WIDTH-1:0] baud_div;

  axi_uart_wr_ctrl i_wr_ctrl (
    .axi_aclk_i, .axi_aresetn_i, .axi_awaddr_i, .axi_awid_i, .axi_awvalid_i,
    .axi_wdata_i, .axi_wvalid_i, .tx_full_i(tx_full),
    .axi_awready_o, .axi_wready_o, .axi_bvalid_o, .axi_bid_o,
    .tx_push_o(tx_push), .tx_data_o(tx_wdata), .dlab_o(dlab), .irq_en_o(irq_en),
    .baud_div_o(baud_div)
  );

  axi_uart_rd_ctrl i_rd_ctrl (
    .axi_aclk_i, .axi_aresetn_i, .axi_araddr_i, .axi_arid_i, .axi_arvalid_i,
    .dlab_i(dlab), .irq_en_i(irq_en), .rx_head_i(rx_head), .rx_empty_i(rx_empty),
    .tx_full_i(tx_full), .tx_empty_i(tx_empty), .tx_busy_i(tx_busy),
    .axi_arready_o, .axi_rvalid_o, .axi_rdata_o, .axi_rid_o,
    .rx_pop_o(rx_pop), .read_interrupt_o
  );

  sync_fifo #(.payload_t(uart_pkg::uart_byte_t)) i_tx_fifo (
    .axi_aclk_i, .axi_aresetn_i, .push_i(tx_push), .data_i(tx_wdata), .pop_i(tx_pop),
    .data_o(tx_head), .empty_o(tx_empty), .full_o(tx_full)
  );

  sync_fifo #(.payload_t(uart_pkg::rx_entry_t)) i_rx_fifo (
    .axi_aclk_i, .axi_aresetn_i, .push_i(rx_push), .data_i(rx_entry), .pop_i(rx_pop),
    .data_o(rx_head), .empty_o(rx_empty), .full_o() // overflow drops bytes silently
  );

  uart_tx_serializer i_tx_ser (
    .axi_aclk_i, .axi_aresetn_i, .baud_div_i(baud_div), .fifo_data_i(tx_head),
    .fifo_empty_i(tx_empty), .fifo_pop_o(tx_pop), .busy_o(tx_busy), .uart_tx_o
  );

  uart_rx_deserializer i_rx_deser (
    .axi_aclk_i, .axi_aresetn_i, .baud_div_i(baud_div), .uart_rx_i,
    .push_o(rx_push), .entry_o(rx_entry)
  );

endmodule

//--- verif/tb_axi_uart.sv
// ----------------------------------------------------------------------
// tb_axi_uart
// testbench for the AXI UART, bus tasks, serial loopback and frame driver
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_axi_uart;

  localparam int         BIT_CLKS     = 8;   // divisor programmed below
  localparam int         RESP_TIMEOUT = 16;  // cycles per bus handshake
  localparam int         LSR_POLLS    = 100;
  localparam int         IRQ_TIMEOUT  = 8;
  localparam logic [4:0] RBR_ADDR     = {uart_pkg::REG_RBR_THR, 2'b00};
  localparam logic [4:0] IER_ADDR     = {uart_pkg::REG_IER, 2'b00};
  localparam logic [4:0] LCR_ADDR     = {uart_pkg::REG_LCR, 2'b00};
  localparam logic [4:0] LSR_ADDR     = {uart_pkg::REG_LSR, 2'b00};
  localparam logic [4:0] DIV_ADDR     = {uart_pkg::REG_DIV, 2'b00};
  localparam logic [7:0] LSR_DR       = 8'h01 << uart_pkg::LSR_DATA_READY;
  localparam logic [7:0] LSR_FE       = 8'h01 << uart_pkg::LSR_FRAME_ERR;
  localparam logic [7:0] LSR_TE       = 8'h01 << uart_pkg::LSR_TX_EMPTY;

  logic        axi_aclk;
  logic        axi_aresetn;
  logic [4:0]  araddr, awaddr;
  logic [3:0]  arid, awid, rid, bid;
  logic        arvalid, arready, rvalid, awvalid, awready, wvalid, wready, bvalid;
  logic [31:0] wdata, rdata;
  logic        read_interrupt, uart_rx, uart_tx;
  logic        loopback, rx_line;           // serial line select and driver
  logic [3:0]  exp_awid, exp_arid;
  logic        tx_quiet, irq_masked, irq_hold; // windows for the assertions
  int          check_errors, other_errors;

  assign uart_rx = loopback ? uart_tx : rx_line;

  axi_uart_top i_dut (
    .axi_aclk_i(axi_aclk), .axi_aresetn_i(axi_aresetn),
    .axi_araddr_i(araddr), .axi_arid_i(arid), .axi_arvalid_i(arvalid),
    .axi_arready_o(arready), .axi_rvalid_o(rvalid), .axi_rdata_o(rdata), .axi_rid_o(rid),
    .axi_awaddr_i(awaddr), .axi_awid_i(awid), .axi_awvalid_i(awvalid),
    .axi_awready_o(awready), .axi_wdata_i(wdata), .axi_wvalid_i(wvalid),
    .axi_wready_o(wready), .axi_bvalid_o(bvalid), .axi_bid_o(bid),
    .read_interrupt_o(read_interrupt), .uart_rx_i(uart_rx), .uart_tx_o(uart_tx)
  );

  initial begin
    axi_aclk = 1'b0;
    forever #2 axi_aclk = ~axi_aclk; // 4 ns period
  end

  a_bvalid_pulse: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    bvalid |=> !bvalid)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t axi_bvalid_o expected 0 got 1", $time);
    end
  a_bid_echo: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    bvalid |-> bid == exp_awid)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t axi_bid_o expected %h got %h", $time, exp_awid,
               $sampled(bid));
    end
  // awready and wready pulse together with bvalid
  a_awready_match: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    awready == bvalid)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t axi_awready_o expected %0b got %0b", $time,
               $sampled(bvalid), $sampled(awready));
    end
  a_wready_match: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    wready == bvalid)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t axi_wready_o expected %0b got %0b", $time,
               $sampled(bvalid), $sampled(wready));
    end
  a_rvalid_pulse: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    rvalid |=> !rvalid)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t axi_rvalid_o expected 0 got 1", $time);
    end
  a_arready_drop: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    rvalid |-> !arready)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t axi_arready_o expected 0 got 1", $time);
    end
  a_arready_back: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    rvalid |=> arready)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t axi_arready_o expected 1 got 0", $time);
    end
  a_rid_echo: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    rvalid |-> rid == exp_arid)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t axi_rid_o expected %h got %h", $time, exp_arid,
               $sampled(rid));
    end
  a_tx_quiet: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    tx_quiet |-> uart_tx)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t uart_tx_o expected 1 got 0", $time);
    end
  a_irq_masked: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    irq_masked |-> !read_interrupt)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t read_interrupt_o expected 0 got 1", $time);
    end
  a_irq_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    irq_hold |-> read_interrupt)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t read_interrupt_o expected 1 got 0", $time);
    end

  task automatic expect_equal(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
    assert (act_val === exp_val)
    else begin
      check_errors++;
      $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic bus_write(input logic [4:0] addr, input logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge axi_aclk);
    exp_awid = 4'($urandom);
    awaddr   = addr;
    awid     = exp_awid;
    wdata    = data;
    awvalid  = 1'b1;
    wvalid   = 1'b1;
    do begin
      @(negedge axi_aclk);
      waited++;
    end while (!bvalid && waited < RESP_TIMEOUT);
    awvalid = 1'b0; // drop before the machine is idle again
    wvalid  = 1'b0;
    if (!bvalid) begin
      other_errors++;
      $display("write to address %h got no response in time", addr);
    end
  endtask

  task automatic bus_read(input logic [4:0] addr, output logic [31:0] data);
    int waited;
    waited = 0;
    @(negedge axi_aclk);
    while (!arready && waited < RESP_TIMEOUT) begin
      @(negedge axi_aclk);
      waited++;
    end
    if (!arready) begin
      other_errors++;
      $display("read address channel never became ready");
    end
    exp_arid = 4'($urandom);
    araddr   = addr;
    arid     = exp_arid;
    arvalid  = 1'b1;
    waited   = 0;
    do begin
      @(negedge axi_aclk);
      waited++;
    end while (!rvalid && waited < RESP_TIMEOUT);
    arvalid = 1'b0;
    data    = rdata;
    if (!rvalid) begin
      other_errors++;
      $display("read from address %h got no response in time", addr);
    end
  endtask

  task automatic wait_lsr(input logic [7:0] mask, input logic [7:0] value,
                          output logic [7:0] lsr);
    logic [31:0] rd;
    int          polls;
    polls = 0;
    do begin
      bus_read(LSR_ADDR, rd);
      polls++;
    end while ((rd[7:0] & mask) != value && polls < LSR_POLLS);
    lsr = rd[7:0];
    if ((lsr & mask) != value) begin
      other_errors++;
      $display("LSR never reached %h under mask %h, last value %h", value, mask, lsr);
    end
  endtask

  task automatic wait_irq(input logic level);
    int waited;
    waited = 0;
    while (read_interrupt !== level && waited < IRQ_TIMEOUT) begin
      @(negedge axi_aclk);
      waited++;
    end
    if (read_interrupt !== level) begin
      other_errors++;
      $display("read interrupt did not settle at %0b in time", level);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge axi_aclk);
  endtask

  // start bit, lsb first data, chosen stop level, then one idle bit
  task automatic send_frame(input uart_pkg::uart_byte_t data, input logic stop_bit);
    logic [9:0] frame;
    int         i;
    frame = {stop_bit, data, 1'b0};
    @(negedge axi_aclk);
    for (i = 0; i < 10; i++) begin
      rx_line = frame[i];
      wait_cycles(BIT_CLKS);
    end
    rx_line = 1'b1;
    wait_cycles(BIT_CLKS);
  endtask

  task automatic read_rbr_expect(input uart_pkg::uart_byte_t exp_byte);
    logic [31:0] rd;
    bus_read(RBR_ADDR, rd);
    expect_equal("axi_rdata_o (RBR)", {24'h0, exp_byte}, rd);
  endtask

  initial begin
    logic [31:0]          rd;
    logic [7:0]           lsr;
    uart_pkg::uart_byte_t b0;
    uart_pkg::uart_byte_t b1;
    int                   n;
    void'($urandom(32'h0b7f_b0f5));
    {araddr, awaddr, arid, awid, wdata} = '0;
    {arvalid, awvalid, wvalid}          = '0;
    {exp_awid, exp_arid}                = '0;
    {tx_quiet, irq_masked, irq_hold}    = '0;
    check_errors = 0;
    other_errors = 0;
    loopback     = 1'b0;
    rx_line      = 1'b1;
    axi_aresetn  = 1'b0;
    wait_cycles(5);
    expect_equal("axi_arready_o", 32'd0, 32'(arready));
    expect_equal("axi_bvalid_o", 32'd0, 32'(bvalid));
    expect_equal("read_interrupt_o", 32'd0, 32'(read_interrupt));
    expect_equal("uart_tx_o", 32'd1, 32'(uart_tx));
    axi_aresetn = 1'b1;

    bus_read(LSR_ADDR, rd); // also waits for arready after reset
    expect_equal("axi_rdata_o (LSR)", 32'h60, rd);

    // loopback at 8 clocks per bit
    bus_write(LCR_ADDR, 32'h80);
    bus_write(DIV_ADDR, 32'(BIT_CLKS));
    bus_write(LCR_ADDR, 32'h00);
    loopback = 1'b1;
    for (n = 0; n < 6; n++) begin
      b0 = 8'($urandom);
      bus_write(RBR_ADDR, {24'h0, b0});
      wait_lsr(LSR_DR, LSR_DR, lsr);
      expect_equal("axi_rdata_o (LSR frame error)", 32'd0, 32'(lsr & LSR_FE));
      read_rbr_expect(b0);
    end
    wait_lsr(LSR_DR | LSR_TE, LSR_TE, lsr);
    loopback = 1'b0;

    // DLAB gates THR and RBR
    b0 = 8'($urandom);
    send_frame(b0, 1'b1);
    wait_lsr(LSR_DR, LSR_DR, lsr);
    bus_write(LCR_ADDR, 32'h80);
    tx_quiet = 1'b1;
    bus_write(RBR_ADDR, 32'h0000_00a5); // refused
    wait_cycles(20 * BIT_CLKS);
    tx_quiet = 1'b0;
    bus_read(RBR_ADDR, rd);
    expect_equal("axi_rdata_o (RBR, DLAB set)", 32'd0, rd);
    bus_read(LSR_ADDR, rd);
    expect_equal("axi_rdata_o (LSR data ready)", 32'(LSR_DR), rd & 32'(LSR_DR));
    bus_write(LCR_ADDR, 32'h00);
    read_rbr_expect(b0);

    // interrupt masked, then enabled
    irq_masked = 1'b1;
    b0 = 8'($urandom);
    b1 = 8'($urandom);
    send_frame(b0, 1'b1);
    send_frame(b1, 1'b1);
    wait_lsr(LSR_DR, LSR_DR, lsr);
    wait_cycles(10);
    irq_masked = 1'b0;
    bus_write(IER_ADDR, 32'h1);
    wait_irq(1'b1);
    irq_hold = 1'b1;
    read_rbr_expect(b0);
    read_rbr_expect(b1);
    irq_hold = 1'b0;
    wait_irq(1'b0);
    bus_write(IER_ADDR, 32'h0);

    // stop bit driven low
    b0 = 8'($urandom);
    send_frame(b0, 1'b0);
    wait_lsr(LSR_DR, LSR_DR, lsr);
    expect_equal("axi_rdata_o (LSR frame error)", 32'(LSR_FE), 32'(lsr & LSR_FE));
    read_rbr_expect(b0);
    wait_lsr(LSR_DR | LSR_FE, 8'h00, lsr);

    wait_cycles(4);
    $display("error counts: check %0d, other %0d", check_errors, other_errors);
    if (check_errors == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- build.f
logic/uart_pkg.sv
logic/sync_fifo.sv
logic/uart_tx_serializer.sv
logic/uart_rx_deserializer.sv
logic/axi_uart_wr_ctrl.sv
logic/axi_uart_rd_ctrl.sv
logic/axi_uart_top.sv
verif/tb_axi_uart.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the AXI UART testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_axi_uart -f build.f \
  -o tb_axi_uart > sim.log 2>&1 &&
  ./obj_dir/tb_axi_uart >> sim.log 2>&1
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "NO ERRORS" sim.log && { echo "simulation passed"; exit 0; } ||
  { echo "simulation did not complete, see sim.log"; exit 1; }
